// ==== include/sdhc_params.svh ====
`ifndef SDHC_PARAMS_SVH
`define SDHC_PARAMS_SVH

// AXI4-Lite bus widths
`define SDHC_DATA_W 32
`define SDHC_ADDR_W 32
// word index sits just above the byte lane bits
`define SDHC_IDX_W 6
`define SDHC_RESP_OKAY 2'b00

// register word indices
`define SDHC_REG_ARG2 6'h00
`define SDHC_REG_BLK 6'h01
`define SDHC_REG_ARG1 6'h02
`define SDHC_REG_CMD 6'h03
`define SDHC_REG_RESP0 6'h04
`define SDHC_REG_RESP1 6'h05
`define SDHC_REG_RESP2 6'h06
`define SDHC_REG_RESP3 6'h07
`define SDHC_REG_PSTATE 6'h09
`define SDHC_REG_HOSTCTL 6'h0A
`define SDHC_REG_CLKCTL 6'h0B
`define SDHC_REG_INTSTAT 6'h0C
`define SDHC_REG_INTEN 6'h0D
`define SDHC_REG_SIGEN 6'h0E
`define SDHC_REG_ACMDERR 6'h0F
`define SDHC_REG_CAP0 6'h10
`define SDHC_REG_CAP1 6'h11
`define SDHC_REG_ADMA 6'h16
`define SDHC_REG_VERSION 6'h3F

// read-only identification words
`define SDHC_CAP0 32'h012C32B2
`define SDHC_CAP1 32'h00000005
`define SDHC_VERSION 32'h00020000

// CMD23 command word and the card status expected back
`define SDHC_ACMD23_CMD 14'h171A
`define SDHC_ACMD23_OK 16'h0900

// one-hot data timeout, 2^(field + base)
`define SDHC_TOUT_BASE 13
`define SDHC_TOUT_W 29

`endif

// ==== hw/axi_lite_pkg.sv ====
package axi_lite_pkg;

`include "sdhc_params.svh"

	// write address, write data and write response ready
	typedef struct packed {
		logic [`SDHC_ADDR_W-1:0] awaddr;
		logic awvalid;
		logic [`SDHC_DATA_W-1:0] wdata;
		logic [`SDHC_DATA_W/8-1:0] wstrb;
		logic wvalid;
		logic bready;
	} axi_lite_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
	} axi_lite_wr_rsp_t;

	typedef struct packed {
		logic [`SDHC_ADDR_W-1:0] araddr;
		logic arvalid;
		logic rready;
	} axi_lite_rd_req_t;

	typedef struct packed {
		logic arready;
		logic rvalid;
		logic [1:0] rresp;
		logic [`SDHC_DATA_W-1:0] rdata;
	} axi_lite_rd_rsp_t;

	// single-cycle register write toward the register file
	typedef struct packed {
		logic stb;
		logic [`SDHC_IDX_W-1:0] idx;
		logic [`SDHC_DATA_W-1:0] data;
		logic [`SDHC_DATA_W/8-1:0] be;
	} reg_wr_t;

	// register read select, valid while the read is accepted
	typedef struct packed {
		logic stb;
		logic [`SDHC_IDX_W-1:0] idx;
	} reg_rd_t;

endpackage

// ==== hw/sdhc_pkg.sv ====
package sdhc_pkg;

`include "sdhc_params.svh"

	// command line events, level while the line logic holds them
	typedef struct packed {
		logic index;
		logic end_bit;
		logic crc;
		logic timeout;
		logic dc;
		logic cc;
	} cmd_evt_t;

	typedef struct packed {
		logic busy_end;
		logic timeout;
		logic crc;
		logic end_bit;
	} dat_evt_t;

	typedef struct packed {
		logic cmd_inhibit_clr;
		logic dat_inhibit;
		logic dat_line_active;
		logic read_active;
		logic write_active;
	} line_status_t;

	// everything the register block hands to the controller core
	typedef struct packed {
		logic [7:0] clock_divisor;
		logic [`SDHC_TOUT_W-1:0] data_timeout;
		logic [1:0] sw_reset;
		logic bus_4bit;
		logic bus_8bit;
		logic ddr_en;
		logic blk_gap_req;
		logic xfer_dir;
		logic [1:0] dma_blkcnt_en;
		logic [11:0] block_size;
		logic [15:0] block_count;
		logic [`SDHC_ADDR_W-1:0] adma_addr;
		logic [28:0] int_stat_en;
		logic [28:0] int_sig_en;
	} host_ctl_t;

	// status clear request, per-byte enables over the 29 status bits
	typedef struct packed {
		logic stb;
		logic [3:0] be;
		logic [28:0] mask;
	} int_clr_t;

	// transfer-mode/command word layout
	typedef struct packed {
		logic [1:0] rsvd_hi;
		logic [13:0] cmd_field;
		logic [10:0] rsvd_lo;
		logic dir;
		logic [1:0] acmd_mode;
		logic [1:0] dma_blkcnt;
	} cmd_fields_t;

	// written as strobed bytes, decoded as fields
	typedef union packed {
		logic [3:0][7:0] bytes;
		cmd_fields_t f;
	} cmd_xfer_u;

	typedef enum logic [1:0] {IDLE, WAIT_CC, SEND} acmd_state_e;

endpackage

// ==== hw/axi_lite_slave.sv ====
`timescale 1ns/100ps
`include "sdhc_params.svh"

module axi_lite_slave
	import axi_lite_pkg::*;
(
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  axi_lite_wr_req_t wr_req_i,
	input  axi_lite_rd_req_t rd_req_i,
	input  logic [`SDHC_DATA_W-1:0] rd_data_i,
	output axi_lite_wr_rsp_t wr_rsp_o,
	output axi_lite_rd_rsp_t rd_rsp_o,
	output reg_wr_t reg_wr_o,
	output reg_rd_t reg_rd_o
);
	localparam int ADDR_LSB = $clog2(`SDHC_DATA_W / 8);

	logic wr_ready_q;
	logic bvalid_q;
	logic wr_stb_q;
	logic [`SDHC_IDX_W-1:0] aw_idx_q;
	logic [`SDHC_DATA_W-1:0] wr_data_q;
	logic [`SDHC_DATA_W/8-1:0] wr_be_q;
	logic ar_ready_q;
	logic rvalid_q;
	logic [`SDHC_IDX_W-1:0] ar_idx_q;
	logic [`SDHC_DATA_W-1:0] rdata_q;
	logic wr_accept;
	logic wr_done;
	logic rd_accept;
	logic rd_done;

	// both valids seen, no ready pending and the last response taken
	assign wr_accept = !wr_ready_q && wr_req_i.awvalid && wr_req_i.wvalid && !bvalid_q;
	assign wr_done = wr_ready_q && wr_req_i.awvalid && wr_req_i.wvalid;
	// one read in flight at a time
	assign rd_accept = !ar_ready_q && rd_req_i.arvalid && !rvalid_q;
	assign rd_done = ar_ready_q && rd_req_i.arvalid && !rvalid_q;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ready_q <= 1'b0;
			bvalid_q <= 1'b0;
			wr_stb_q <= 1'b0;
			ar_ready_q <= 1'b0;
			rvalid_q <= 1'b0;
		end
		else
		begin
			// AWREADY and WREADY share one pulse
			wr_ready_q <= wr_accept;
			wr_stb_q <= wr_done;
			if (wr_done)
				bvalid_q <= 1'b1;
			else if (wr_req_i.bready)
				bvalid_q <= 1'b0;
			ar_ready_q <= rd_accept;
			if (rd_done)
				rvalid_q <= 1'b1;
			else if (rd_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	// latched addresses and write payload
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_accept)
			aw_idx_q <= wr_req_i.awaddr[ADDR_LSB +: `SDHC_IDX_W];
		if (wr_done)
		begin
			wr_data_q <= wr_req_i.wdata;
			wr_be_q <= wr_req_i.wstrb;
		end
		if (rd_accept)
			ar_idx_q <= rd_req_i.araddr[ADDR_LSB +: `SDHC_IDX_W];
		// read word sampled as the address phase closes
		if (rd_done)
			rdata_q <= rd_data_i;
	end

	// aw index stays put until the next accept, after BVALID drops
	assign reg_wr_o.stb = wr_stb_q;
	assign reg_wr_o.idx = aw_idx_q;
	assign reg_wr_o.data = wr_data_q;
	assign reg_wr_o.be = wr_be_q;

	assign reg_rd_o.stb = rd_done;
	assign reg_rd_o.idx = ar_idx_q;

	assign wr_rsp_o.awready = wr_ready_q;
	assign wr_rsp_o.wready = wr_ready_q;
	assign wr_rsp_o.bvalid = bvalid_q;
	assign wr_rsp_o.bresp = `SDHC_RESP_OKAY;

	assign rd_rsp_o.arready = ar_ready_q;
	assign rd_rsp_o.rvalid = rvalid_q;
	assign rd_rsp_o.rresp = `SDHC_RESP_OKAY;
	assign rd_rsp_o.rdata = rdata_q;

endmodule

// ==== hw/host_reg_file.sv ====
`timescale 1ns/100ps
`include "sdhc_params.svh"

module host_reg_file
	import axi_lite_pkg::*;
	import sdhc_pkg::*;
(
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  reg_wr_t reg_wr_i,
	input  reg_rd_t reg_rd_i,
	input  logic [3:0][`SDHC_DATA_W-1:0] resp_i,
	input  line_status_t line_status_i,
	input  logic clk_stable_i,
	input  logic [28:0] int_stat_i,
	input  logic [7:0] acmd_err_status_i,
	output logic [`SDHC_DATA_W-1:0] rd_data_o,
	output host_ctl_t host_ctl_o,
	output cmd_xfer_u cmd_xfer_o,
	output logic [`SDHC_DATA_W-1:0] arg1_o,
	output logic [`SDHC_DATA_W-1:0] arg2_o,
	output logic cmd_start_req_o,
	output int_clr_t int_clr_wr_o,
	output logic dat_int_rst_o
);
	logic [`SDHC_DATA_W-1:0] arg1_q;
	logic [`SDHC_DATA_W-1:0] arg2_q;
	logic [`SDHC_DATA_W-1:0] adma_q;
	logic [`SDHC_DATA_W-1:0] blk_q;
	logic [`SDHC_DATA_W-1:0] hostctl_q;
	logic [`SDHC_DATA_W-1:0] clkctl_q;
	logic [`SDHC_DATA_W-1:0] inten_q;
	logic [`SDHC_DATA_W-1:0] sigen_q;
	logic [`SDHC_DATA_W-1:0] pstate_q;
	logic [15:0] hc2_q;
	cmd_xfer_u cmd_q;
	logic [`SDHC_DATA_W-1:0] rd_word;

	function automatic logic [`SDHC_DATA_W-1:0] merge_be(input logic [`SDHC_DATA_W-1:0] cur,
			input logic [`SDHC_DATA_W-1:0] wd, input logic [3:0] be);
		logic [`SDHC_DATA_W-1:0] res;
		res = cur;
		for (int i = 0; i < 4; i++)
			if (be[i])
				res[i*8 +: 8] = wd[i*8 +: 8];
		return res;
	endfunction

	// upper-half-only command write launches the command
	assign cmd_start_req_o = reg_wr_i.stb && reg_wr_i.idx == `SDHC_REG_CMD &&
		reg_wr_i.be == 4'b1100;
	assign int_clr_wr_o.stb = reg_wr_i.stb && reg_wr_i.idx == `SDHC_REG_INTSTAT;
	assign int_clr_wr_o.be = reg_wr_i.be;
	assign int_clr_wr_o.mask = reg_wr_i.data[28:0];
	assign dat_int_rst_o = int_clr_wr_o.stb;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			blk_q <= '0;
			cmd_q <= '0;
			hostctl_q <= '0;
			clkctl_q <= '0;
			inten_q <= '0;
			sigen_q <= '0;
			hc2_q <= '0;
			pstate_q <= '0;
		end
		else
		begin
			// software reset request lasts a single cycle
			clkctl_q[26:24] <= 3'b000;
			if (reg_wr_i.stb)
			begin
				case (reg_wr_i.idx)
					`SDHC_REG_BLK: blk_q <= merge_be(blk_q, reg_wr_i.data, reg_wr_i.be);
					`SDHC_REG_CMD:
						for (int i = 0; i < 4; i++)
							if (reg_wr_i.be[i])
								cmd_q.bytes[i] <= reg_wr_i.data[i*8 +: 8];
					`SDHC_REG_HOSTCTL: hostctl_q <= merge_be(hostctl_q, reg_wr_i.data, reg_wr_i.be);
					`SDHC_REG_CLKCTL: clkctl_q <= merge_be(clkctl_q, reg_wr_i.data, reg_wr_i.be);
					`SDHC_REG_INTEN: inten_q <= merge_be(inten_q, reg_wr_i.data, reg_wr_i.be);
					`SDHC_REG_SIGEN: sigen_q <= merge_be(sigen_q, reg_wr_i.data, reg_wr_i.be);
					`SDHC_REG_ACMDERR:
					begin
						// only host control 2 in the upper half is writable
						if (reg_wr_i.be[2])
							hc2_q[7:0] <= reg_wr_i.data[23:16];
						if (reg_wr_i.be[3])
							hc2_q[15:8] <= reg_wr_i.data[31:24];
					end
					default: ;
				endcase
			end
			// internal clock stable, read only
			clkctl_q[1] <= clk_stable_i;
			// present state, bit 0 is command inhibit
			pstate_q <= {7'b0, 1'b1, {4{~line_status_i.dat_line_active}}, 4'hF, 6'b0,
				line_status_i.read_active, line_status_i.write_active, 5'b0,
				line_status_i.dat_line_active,
				line_status_i.dat_inhibit | line_status_i.read_active,
				cmd_start_req_o | (pstate_q[0] & ~line_status_i.cmd_inhibit_clr)};
		end
	end

	// argument and DMA address words
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (reg_wr_i.stb && reg_wr_i.idx == `SDHC_REG_ARG2)
			arg2_q <= merge_be(arg2_q, reg_wr_i.data, reg_wr_i.be);
		if (reg_wr_i.stb && reg_wr_i.idx == `SDHC_REG_ARG1)
			arg1_q <= merge_be(arg1_q, reg_wr_i.data, reg_wr_i.be);
		if (reg_wr_i.stb && reg_wr_i.idx == `SDHC_REG_ADMA)
			adma_q <= merge_be(adma_q, reg_wr_i.data, reg_wr_i.be);
	end

	always_comb
	begin
		case (reg_rd_i.idx)
			`SDHC_REG_ARG2: rd_word = arg2_q;
			`SDHC_REG_BLK: rd_word = blk_q;
			`SDHC_REG_ARG1: rd_word = arg1_q;
			`SDHC_REG_CMD: rd_word = cmd_q;
			`SDHC_REG_RESP0: rd_word = resp_i[0];
			`SDHC_REG_RESP1: rd_word = resp_i[1];
			`SDHC_REG_RESP2: rd_word = resp_i[2];
			`SDHC_REG_RESP3: rd_word = resp_i[3];
			`SDHC_REG_PSTATE: rd_word = pstate_q;
			`SDHC_REG_HOSTCTL: rd_word = hostctl_q;
			`SDHC_REG_CLKCTL: rd_word = clkctl_q;
			// only enabled status bits are visible
			`SDHC_REG_INTSTAT: rd_word = {3'b000, int_stat_i & inten_q[28:0]};
			`SDHC_REG_INTEN: rd_word = inten_q;
			`SDHC_REG_SIGEN: rd_word = sigen_q;
			`SDHC_REG_ACMDERR: rd_word = {hc2_q, 8'h00, acmd_err_status_i};
			`SDHC_REG_CAP0: rd_word = `SDHC_CAP0;
			`SDHC_REG_CAP1: rd_word = `SDHC_CAP1;
			`SDHC_REG_ADMA: rd_word = adma_q;
			`SDHC_REG_VERSION: rd_word = `SDHC_VERSION;
			default: rd_word = '0;
		endcase
	end

	// read word only driven while a read is being accepted
	assign rd_data_o = reg_rd_i.stb ? rd_word : '0;

	assign cmd_xfer_o = cmd_q;
	assign arg1_o = arg1_q;
	assign arg2_o = arg2_q;

	assign host_ctl_o.clock_divisor = clkctl_q[15:8];
	assign host_ctl_o.data_timeout = `SDHC_TOUT_W'(1) <<
		(5'(clkctl_q[19:16]) + 5'(`SDHC_TOUT_BASE));
	// bit 24 resets all, then command line, then data line
	assign host_ctl_o.sw_reset = clkctl_q[24] ? 2'b11 :
		clkctl_q[25] ? 2'b01 :
		clkctl_q[26] ? 2'b10 : 2'b00;
	assign host_ctl_o.bus_4bit = hostctl_q[1];
	assign host_ctl_o.bus_8bit = hostctl_q[5];
	assign host_ctl_o.blk_gap_req = hostctl_q[16];
	// DDR enable lives in host control 2, bit 18 of ACMDERR
	assign host_ctl_o.ddr_en = hc2_q[2];
	assign host_ctl_o.xfer_dir = cmd_q.f.dir;
	assign host_ctl_o.dma_blkcnt_en = cmd_q.f.dma_blkcnt;
	assign host_ctl_o.block_size = blk_q[11:0];
	assign host_ctl_o.block_count = blk_q[31:16];
	assign host_ctl_o.adma_addr = adma_q;
	assign host_ctl_o.int_stat_en = inten_q[28:0];
	assign host_ctl_o.int_sig_en = sigen_q[28:0];

endmodule

// ==== hw/int_status_unit.sv ====
`timescale 1ns/100ps

module int_status_unit
	import sdhc_pkg::*;
(
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  cmd_evt_t cmd_evt_i,
	input  dat_evt_t dat_evt_i,
	input  logic [1:0] dma_evt_i,
	input  logic cc_mask_i,
	input  logic acmd_err_i,
	input  int_clr_t int_clr_wr_i,
	output logic [28:0] int_stat_o
);
	logic [28:0] clr_mask_q;
	logic [28:0] stat_q;
	logic [28:0] evt_raw;
	logic [28:0] wr_bits;
	logic any_evt;

	assign any_evt = (|cmd_evt_i) || (|dat_evt_i);

	// byte enables spread over the status bits
	assign wr_bits = int_clr_wr_i.stb ? {{5{int_clr_wr_i.be[3]}}, {8{int_clr_wr_i.be[2]}},
		{8{int_clr_wr_i.be[1]}}, {8{int_clr_wr_i.be[0]}}} : '0;

	always_comb
	begin
		evt_raw = '0;
		// command complete hidden while CMD23 runs
		evt_raw[0] = cmd_evt_i.cc & ~cc_mask_i;
		// dma_evt_i[0] is DMA done
		evt_raw[1] = cmd_evt_i.dc | dma_evt_i[0];
		evt_raw[16] = cmd_evt_i.timeout;
		evt_raw[17] = cmd_evt_i.crc;
		evt_raw[18] = cmd_evt_i.end_bit;
		evt_raw[19] = cmd_evt_i.index;
		evt_raw[20] = dat_evt_i.timeout;
		evt_raw[21] = dat_evt_i.crc;
		evt_raw[22] = dat_evt_i.end_bit;
		evt_raw[24] = acmd_err_i;
		evt_raw[25] = dma_evt_i[1];
		evt_raw[28] = dat_evt_i.busy_end;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			clr_mask_q <= '0;
			stat_q <= '0;
		end
		else
		begin
			// mask drops once every event is gone, written bytes win
			clr_mask_q <= ((any_evt ? clr_mask_q : '0) & ~wr_bits) |
				(int_clr_wr_i.mask & wr_bits);
			stat_q <= evt_raw & ~clr_mask_q;
		end
	end

	assign int_stat_o = stat_q;

endmodule

// ==== hw/auto_cmd23_seq.sv ====
`timescale 1ns/100ps
`include "sdhc_params.svh"

module auto_cmd23_seq
	import sdhc_pkg::*;
(
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  cmd_xfer_u cmd_xfer_i,
	input  logic [`SDHC_DATA_W-1:0] arg1_i,
	input  logic [`SDHC_DATA_W-1:0] arg2_i,
	input  logic cmd_start_req_i,
	input  logic int_clr_wr_i,
	input  cmd_evt_t cmd_evt_i,
	input  logic [15:0] resp0_i,
	input  logic cc_pulse_i,
	output logic [13:0] command_o,
	output logic [`SDHC_DATA_W-1:0] argument_o,
	output logic cmd_start_o,
	output logic cmd_int_rst_o,
	output logic cc_mask_o,
	output logic acmd_err_o,
	output logic [7:0] acmd_err_status_o
);
	acmd_state_e state_q;
	logic sel_q;
	logic start_q;
	logic int_rst_q;
	logic err_q;
	logic [7:0] err_stat_q;
	logic acmd23_en;

	// auto command mode 2'b10 asks for CMD23 first
	assign acmd23_en = cmd_xfer_i.f.acmd_mode == 2'b10;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state_q <= IDLE;
			sel_q <= 1'b0;
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			err_q <= 1'b0;
			err_stat_q <= '0;
		end
		else
		begin
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			case (state_q)
				IDLE:
				begin
					sel_q <= acmd23_en;
					// software start goes out as CMD23
					if (acmd23_en && cmd_start_req_i)
						state_q <= WAIT_CC;
				end
				WAIT_CC:
				begin
					// clear CMD23 events before the real command
					int_rst_q <= |cmd_evt_i;
					if (cc_pulse_i)
					begin
						if (resp0_i == `SDHC_ACMD23_OK)
						begin
							sel_q <= 1'b0;
							start_q <= 1'b1;
							state_q <= SEND;
						end
						else
						begin
							// card status bad, report the line errors
							err_q <= 1'b1;
							err_stat_q <= {3'b000, cmd_evt_i.index, cmd_evt_i.end_bit,
								cmd_evt_i.crc, cmd_evt_i.timeout, 1'b0};
							state_q <= IDLE;
						end
					end
				end
				SEND:
					if (cc_pulse_i)
						state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
			if (int_clr_wr_i)
				err_q <= 1'b0;
		end
	end

	assign command_o = sel_q ? `SDHC_ACMD23_CMD : cmd_xfer_i.f.cmd_field;
	assign argument_o = sel_q ? arg2_i : arg1_i;
	assign cmd_start_o = cmd_start_req_i | start_q;
	assign cmd_int_rst_o = int_clr_wr_i | int_rst_q;
	assign cc_mask_o = sel_q;
	assign acmd_err_o = err_q;
	assign acmd_err_status_o = err_stat_q;

endmodule

// ==== hw/sdhc_axi_regs_top.sv ====
`timescale 1ns/100ps
`include "sdhc_params.svh"

module sdhc_axi_regs_top
	import axi_lite_pkg::*;
	import sdhc_pkg::*;
(
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  axi_lite_wr_req_t axi_wr_req_i,
	input  axi_lite_rd_req_t axi_rd_req_i,
	input  logic [3:0][`SDHC_DATA_W-1:0] resp_i,
	input  cmd_evt_t cmd_evt_i,
	input  dat_evt_t dat_evt_i,
	input  logic [1:0] dma_evt_i,
	input  line_status_t line_status_i,
	input  logic clk_stable_i,
	input  logic cc_pulse_i,
	output axi_lite_wr_rsp_t axi_wr_rsp_o,
	output axi_lite_rd_rsp_t axi_rd_rsp_o,
	output host_ctl_t host_ctl_o,
	output logic [28:0] int_stat_o,
	output logic [13:0] command_o,
	output logic [`SDHC_DATA_W-1:0] argument_o,
	output logic cmd_start_o,
	output logic cmd_int_rst_o,
	output logic dat_int_rst_o
);
	reg_wr_t reg_wr;
	reg_rd_t reg_rd;
	logic [`SDHC_DATA_W-1:0] rd_data;
	cmd_xfer_u cmd_xfer;
	logic [`SDHC_DATA_W-1:0] arg1;
	logic [`SDHC_DATA_W-1:0] arg2;
	logic cmd_start_req;
	int_clr_t int_clr_wr;
	logic cc_mask;
	logic acmd_err;
	logic [7:0] acmd_err_status;

	axi_lite_slave axi_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_req_i(axi_wr_req_i),
		.rd_req_i(axi_rd_req_i),
		.rd_data_i(rd_data),
		.wr_rsp_o(axi_wr_rsp_o),
		.rd_rsp_o(axi_rd_rsp_o),
		.reg_wr_o(reg_wr),
		.reg_rd_o(reg_rd)
	);

	host_reg_file regs_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.reg_wr_i(reg_wr),
		.reg_rd_i(reg_rd),
		.resp_i(resp_i),
		.line_status_i(line_status_i),
		.clk_stable_i(clk_stable_i),
		.int_stat_i(int_stat_o),
		.acmd_err_status_i(acmd_err_status),
		.rd_data_o(rd_data),
		.host_ctl_o(host_ctl_o),
		.cmd_xfer_o(cmd_xfer),
		.arg1_o(arg1),
		.arg2_o(arg2),
		.cmd_start_req_o(cmd_start_req),
		.int_clr_wr_o(int_clr_wr),
		.dat_int_rst_o(dat_int_rst_o)
	);

	int_status_unit ints_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.cmd_evt_i(cmd_evt_i),
		.dat_evt_i(dat_evt_i),
		.dma_evt_i(dma_evt_i),
		.cc_mask_i(cc_mask),
		.acmd_err_i(acmd_err),
		.int_clr_wr_i(int_clr_wr),
		.int_stat_o(int_stat_o)
	);

	// card status is checked against the low half of response 0
	auto_cmd23_seq acmd_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.cmd_xfer_i(cmd_xfer),
		.arg1_i(arg1),
		.arg2_i(arg2),
		.cmd_start_req_i(cmd_start_req),
		.int_clr_wr_i(int_clr_wr.stb),
		.cmd_evt_i(cmd_evt_i),
		.resp0_i(resp_i[0][15:0]),
		.cc_pulse_i(cc_pulse_i),
		.command_o(command_o),
		.argument_o(argument_o),
		.cmd_start_o(cmd_start_o),
		.cmd_int_rst_o(cmd_int_rst_o),
		.cc_mask_o(cc_mask),
		.acmd_err_o(acmd_err),
		.acmd_err_status_o(acmd_err_status)
	);

endmodule

// ==== verification/sdhc_axi_regs_tb.sv ====
`timescale 1ns/100ps
`include "sdhc_params.svh"

module sdhc_axi_regs_tb
	import axi_lite_pkg::*;
	import sdhc_pkg::*;
();
	// six tests of under 400 cycles each, plus room for reset and ready delays
	localparam int TEST_CYCLES = 400;
	localparam int MAX_CYCLES = 6 * TEST_CYCLES + 600;

	logic S_AXI_ACLK = 1'b0;
	logic S_AXI_ARESETN;
	axi_lite_wr_req_t wr_req;
	axi_lite_rd_req_t rd_req;
	axi_lite_wr_rsp_t wr_rsp;
	axi_lite_rd_rsp_t rd_rsp;
	logic [3:0][31:0] resp;
	cmd_evt_t cmd_evt;
	dat_evt_t dat_evt;
	logic [1:0] dma_evt;
	line_status_t line_status;
	logic clk_stable;
	logic cc_pulse;
	host_ctl_t host_ctl;
	logic [28:0] int_stat;
	logic [13:0] command;
	logic [31:0] argument;
	logic cmd_start;
	logic cmd_int_rst;
	logic dat_int_rst;

	integer seed = 73319;
	int errors = 0;
	int errors_mark = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;
	// pulse counters from the monitor below
	int start_cnt = 0;
	int int_rst_cnt = 0;
	int dat_rst_cnt = 0;
	int swrst_cnt = 0;
	logic [1:0] swrst_last = 2'b00;
	logic [31:0] shadow [64];
	int start0;

	sdhc_axi_regs_top dut_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.axi_wr_req_i(wr_req),
		.axi_rd_req_i(rd_req),
		.resp_i(resp),
		.cmd_evt_i(cmd_evt),
		.dat_evt_i(dat_evt),
		.dma_evt_i(dma_evt),
		.line_status_i(line_status),
		.clk_stable_i(clk_stable),
		.cc_pulse_i(cc_pulse),
		.axi_wr_rsp_o(wr_rsp),
		.axi_rd_rsp_o(rd_rsp),
		.host_ctl_o(host_ctl),
		.int_stat_o(int_stat),
		.command_o(command),
		.argument_o(argument),
		.cmd_start_o(cmd_start),
		.cmd_int_rst_o(cmd_int_rst),
		.dat_int_rst_o(dat_int_rst)
	);

	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	// run limit
	always @(posedge S_AXI_ACLK)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	// count single-cycle control pulses
	always @(posedge S_AXI_ACLK)
	begin
		if (cmd_start)
			start_cnt++;
		if (cmd_int_rst)
			int_rst_cnt++;
		if (dat_int_rst)
			dat_rst_cnt++;
		if (host_ctl.sw_reset != 2'b00)
		begin
			swrst_cnt++;
			swrst_last = host_ctl.sw_reset;
		end
	end

	// responses are always OKAY
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_rsp.bvalid |-> wr_rsp.bresp == 2'b00)
	else
	begin
		errors++;
		$display("** Error at %0t: signal bresp got %b expected 00", $time, wr_rsp.bresp);
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rd_rsp.rvalid |-> rd_rsp.rresp == 2'b00)
	else
	begin
		errors++;
		$display("** Error at %0t: signal rresp got %b expected 00", $time, rd_rsp.rresp);
	end

	// address and data ready move as one pulse
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wr_rsp.wready == wr_rsp.awready)
	else
	begin
		errors++;
		$display("** Error at %0t: signal wready got %b expected %b", $time, wr_rsp.wready,
			wr_rsp.awready);
	end

	// software reset lasts one cycle
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		host_ctl.sw_reset != 2'b00 |=> host_ctl.sw_reset == 2'b00)
	else
	begin
		errors++;
		$display("software reset stayed active for more than one cycle at %0t", $time);
	end

	// start never lasts two cycles
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		cmd_start |=> !cmd_start)
	else
	begin
		errors++;
		$display("command start stayed high for more than one cycle at %0t", $time);
	end

	function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++)
			if (be[b])
				res[b*8 +: 8] = new_word[b*8 +: 8];
		return res;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t: signal %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
	endtask

	// random hold-off before taking a response
	task automatic ready_delay();
		int d;
		d = $unsigned($random(seed)) % 9;
		idle(d);
	endtask

	task automatic axi_write(input logic [5:0] idx, input logic [31:0] data,
			input logic [3:0] strb);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.awaddr = {24'b0, idx, 2'b00};
		wr_req.wdata = data;
		wr_req.wstrb = strb;
		wr_req.awvalid = 1'b1;
		wr_req.wvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.awready)
			@(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.awvalid = 1'b0;
		wr_req.wvalid = 1'b0;
		ready_delay();
		wr_req.bready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!wr_rsp.bvalid)
			@(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		wr_req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [5:0] idx, output logic [31:0] data);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.araddr = {24'b0, idx, 2'b00};
		rd_req.arvalid = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.arready)
			@(negedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.arvalid = 1'b0;
		ready_delay();
		rd_req.rready = 1'b1;
		@(negedge S_AXI_ACLK);
		while (!rd_rsp.rvalid)
			@(negedge S_AXI_ACLK);
		data = rd_rsp.rdata;
		@(posedge S_AXI_ACLK);
		#1;
		rd_req.rready = 1'b0;
	endtask

	// write and fold the bytes into the expected register image
	task automatic write_tracked(input logic [5:0] idx, input logic [31:0] data,
			input logic [3:0] strb);
		axi_write(idx, data, strb);
		shadow[idx] = apply_strobes(shadow[idx], data, strb);
	endtask

	task automatic read_expect(input string name, input logic [5:0] idx,
			input logic [31:0] exp);
		logic [31:0] got;
		axi_read(idx, got);
		check_eq(name, got, exp);
	endtask

	task automatic wait_starts(input int target);
		int n;
		n = 0;
		while (start_cnt < target && n < 20)
		begin
			idle(1);
			n++;
		end
		assert (start_cnt >= target)
		else
		begin
			errors++;
			$display("expected command start pulse never came at %0t", $time);
		end
	endtask

	task automatic finish_test(input string name);
		if (errors > errors_mark)
		begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errors_mark);
		end
		else
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		errors_mark = errors;
	endtask

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		wr_req = '0;
		rd_req = '0;
		resp = '0;
		cmd_evt = '0;
		dat_evt = '0;
		dma_evt = 2'b00;
		line_status = '0;
		clk_stable = 1'b1;
		cc_pulse = 1'b0;
		for (int i = 0; i < 64; i++)
			shadow[i] = '0;
		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// byte strobes and host control outputs
		write_tracked(`SDHC_REG_ARG2, 32'hA1B2C3D4, 4'hF);
		write_tracked(`SDHC_REG_ARG2, 32'h11223344, 4'b0101);
		read_expect("arg2", `SDHC_REG_ARG2, shadow[`SDHC_REG_ARG2]);
		write_tracked(`SDHC_REG_BLK, 32'h00100200, 4'hF);
		write_tracked(`SDHC_REG_BLK, 32'h0FFF0000, 4'b1000);
		read_expect("blk", `SDHC_REG_BLK, shadow[`SDHC_REG_BLK]);
		check_eq("block_size", 32'(host_ctl.block_size), 32'h200);
		check_eq("block_count", 32'(host_ctl.block_count), 32'h0F10);
		write_tracked(`SDHC_REG_HOSTCTL, 32'h00010022, 4'hF);
		read_expect("hostctl", `SDHC_REG_HOSTCTL, shadow[`SDHC_REG_HOSTCTL]);
		check_eq("bus_4bit", 32'(host_ctl.bus_4bit), 32'h1);
		check_eq("bus_8bit", 32'(host_ctl.bus_8bit), 32'h1);
		check_eq("blk_gap_req", 32'(host_ctl.blk_gap_req), 32'h1);
		// DDR enable sits in the upper half of ACMDERR
		write_tracked(`SDHC_REG_ACMDERR, 32'h00040000, 4'b0100);
		read_expect("acmderr", `SDHC_REG_ACMDERR, shadow[`SDHC_REG_ACMDERR]);
		check_eq("ddr_en", 32'(host_ctl.ddr_en), 32'h1);
		axi_write(`SDHC_REG_CLKCTL, 32'h01034500, 4'hF);
		idle(2);
		check_eq("sw_reset pulses", swrst_cnt, 1);
		check_eq("sw_reset", 32'(swrst_last), 32'h3);
		check_eq("clock_divisor", 32'(host_ctl.clock_divisor), 32'h45);
		check_eq("data_timeout", 32'(host_ctl.data_timeout),
			32'(29'(1) << (3 + `SDHC_TOUT_BASE)));
		// reset bits gone, clock stable reflected in bit 1
		read_expect("clkctl", `SDHC_REG_CLKCTL, 32'h00034502);
		axi_write(`SDHC_REG_CLKCTL, 32'h02000000, 4'b1000);
		idle(2);
		check_eq("sw_reset pulses", swrst_cnt, 2);
		check_eq("sw_reset", 32'(swrst_last), 32'h1);
		check_eq("sw_reset now", 32'(host_ctl.sw_reset), 32'h0);
		write_tracked(`SDHC_REG_INTEN, 32'h000000FF, 4'b0001);
		write_tracked(`SDHC_REG_INTEN, 32'h1F0F0000, 4'b1100);
		read_expect("inten", `SDHC_REG_INTEN, shadow[`SDHC_REG_INTEN]);
		check_eq("int_stat_en", 32'(host_ctl.int_stat_en), 32'h1F0F00FF);
		write_tracked(`SDHC_REG_SIGEN, 32'h12345678, 4'b0011);
		read_expect("sigen", `SDHC_REG_SIGEN, shadow[`SDHC_REG_SIGEN]);
		check_eq("int_sig_en", 32'(host_ctl.int_sig_en), 32'h00005678);
		write_tracked(`SDHC_REG_ADMA, 32'hDEADBEEF, 4'hF);
		write_tracked(`SDHC_REG_ADMA, 32'h00000055, 4'b0001);
		read_expect("adma", `SDHC_REG_ADMA, shadow[`SDHC_REG_ADMA]);
		check_eq("adma_addr", host_ctl.adma_addr, 32'hDEADBE55);
		finish_test("byte_strobes");

		// read-only words and responses
		read_expect("cap0", `SDHC_REG_CAP0, 32'h012C32B2);
		read_expect("cap1", `SDHC_REG_CAP1, 32'h00000005);
		read_expect("version", `SDHC_REG_VERSION, 32'h00020000);
		resp[0] = 32'h5A5A0900;
		resp[1] = 32'h01234567;
		resp[2] = 32'h89ABCDEF;
		resp[3] = 32'hF0E1D2C3;
		for (int k = 0; k < 4; k++)
			read_expect("resp", 6'(`SDHC_REG_RESP0 + k), resp[k]);
		read_expect("unmapped 08", 6'h08, 32'h0);
		read_expect("unmapped 12", 6'h12, 32'h0);
		read_expect("unmapped 2a", 6'h2A, 32'h0);
		read_expect("unmapped 3e", 6'h3E, 32'h0);
		finish_test("read_only");

		// upper-half command write launches the command
		start0 = start_cnt;
		axi_write(`SDHC_REG_CMD, 32'h0ABC0000, 4'b1100);
		idle(2);
		check_eq("cmd_start pulses", start_cnt, start0 + 1);
		check_eq("command", 32'(command), 32'h0ABC);
		read_expect("pstate", `SDHC_REG_PSTATE, 32'h01FF0001);
		axi_write(`SDHC_REG_CMD, 32'h0ABC0013, 4'hF);
		idle(2);
		check_eq("cmd_start pulses", start_cnt, start0 + 1);
		check_eq("xfer_dir", 32'(host_ctl.xfer_dir), 32'h1);
		check_eq("dma_blkcnt_en", 32'(host_ctl.dma_blkcnt_en), 32'h3);
		read_expect("pstate", `SDHC_REG_PSTATE, 32'h01FF0001);
		line_status.cmd_inhibit_clr = 1'b1;
		line_status.dat_line_active = 1'b1;
		line_status.write_active = 1'b1;
		line_status.read_active = 1'b1;
		idle(1);
		line_status.cmd_inhibit_clr = 1'b0;
		read_expect("pstate", `SDHC_REG_PSTATE, 32'h010F0306);
		line_status = '0;
		finish_test("command_start");

		// interrupt status layout, enable masking and clearing
		cmd_evt.cc = 1'b1;
		cmd_evt.timeout = 1'b1;
		dat_evt.crc = 1'b1;
		dma_evt = 2'b10;
		idle(3);
		check_eq("int_stat", 32'(int_stat), 32'h02210001);
		read_expect("intstat", `SDHC_REG_INTSTAT, 32'h02010001);
		axi_write(`SDHC_REG_INTSTAT, 32'h00210001, 4'hF);
		idle(3);
		check_eq("cmd_int_rst pulses", int_rst_cnt, 1);
		check_eq("dat_int_rst pulses", dat_rst_cnt, 1);
		check_eq("int_stat", 32'(int_stat), 32'h02000000);
		idle(4);
		check_eq("int_stat", 32'(int_stat), 32'h02000000);
		// mask lasts until every event has dropped
		cmd_evt = '0;
		dat_evt = '0;
		dma_evt = 2'b00;
		idle(3);
		check_eq("int_stat", 32'(int_stat), 32'h0);
		cmd_evt.cc = 1'b1;
		cmd_evt.timeout = 1'b1;
		dat_evt.crc = 1'b1;
		dma_evt = 2'b10;
		idle(3);
		check_eq("int_stat", 32'(int_stat), 32'h02210001);
		cmd_evt = '0;
		dat_evt = '0;
		dma_evt = 2'b00;
		idle(3);
		// the other status bits, bit 1 from dc and then from DMA done
		cmd_evt.dc = 1'b1;
		cmd_evt.crc = 1'b1;
		cmd_evt.end_bit = 1'b1;
		cmd_evt.index = 1'b1;
		dat_evt.timeout = 1'b1;
		dat_evt.end_bit = 1'b1;
		dat_evt.busy_end = 1'b1;
		idle(3);
		check_eq("int_stat", 32'(int_stat), 32'h105E0002);
		cmd_evt.dc = 1'b0;
		dma_evt = 2'b01;
		idle(3);
		check_eq("int_stat", 32'(int_stat), 32'h105E0002);
		cmd_evt = '0;
		dat_evt = '0;
		dma_evt = 2'b00;
		idle(3);
		finish_test("interrupt_status");

		// CMD23 goes first, card status good
		resp[0] = 32'h00000900;
		write_tracked(`SDHC_REG_ARG1, 32'h00001234, 4'hF);
		write_tracked(`SDHC_REG_ARG2, 32'h00000008, 4'hF);
		axi_write(`SDHC_REG_CMD, 32'h00000008, 4'b0011);
		idle(2);
		check_eq("command", 32'(command), 32'h171A);
		check_eq("argument", argument, 32'h00000008);
		start0 = start_cnt;
		cmd_evt.cc = 1'b1;
		axi_write(`SDHC_REG_CMD, 32'h0C1A0000, 4'b1100);
		idle(3);
		check_eq("cmd_start pulses", start_cnt, start0 + 1);
		check_eq("int_stat[0]", 32'(int_stat[0]), 32'h0);
		cc_pulse = 1'b1;
		idle(1);
		cc_pulse = 1'b0;
		cmd_evt = '0;
		wait_starts(start0 + 2);
		check_eq("command", 32'(command), 32'h0C1A);
		check_eq("argument", argument, 32'h00001234);
		idle(2);
		// completion of the real command
		cc_pulse = 1'b1;
		idle(1);
		cc_pulse = 1'b0;
		idle(2);
		check_eq("cmd_start pulses", start_cnt, start0 + 2);
		finish_test("acmd23_ok");

		// CMD23 with a bad card status
		axi_write(`SDHC_REG_CMD, 32'h0C1A0000, 4'b1100);
		idle(2);
		resp[0] = 32'h00000B00;
		cmd_evt.crc = 1'b1;
		cmd_evt.index = 1'b1;
		cc_pulse = 1'b1;
		idle(1);
		cc_pulse = 1'b0;
		cmd_evt = '0;
		idle(3);
		check_eq("int_stat[24]", 32'(int_stat[24]), 32'h1);
		read_expect("acmderr", `SDHC_REG_ACMDERR, 32'h00040014);
		read_expect("intstat", `SDHC_REG_INTSTAT, 32'h01000000);
		axi_write(`SDHC_REG_INTSTAT, 32'h01000000, 4'b1000);
		idle(3);
		check_eq("int_stat[24]", 32'(int_stat[24]), 32'h0);
		finish_test("acmd23_err");

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			errors);
		if (tests_failed == 0 && errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hw/axi_lite_pkg.sv
hw/sdhc_pkg.sv
hw/axi_lite_slave.sv
hw/host_reg_file.sv
hw/int_status_unit.sv
hw/auto_cmd23_seq.sv
hw/sdhc_axi_regs_top.sv
verification/sdhc_axi_regs_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= sdhc_axi_regs_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, the copy on stdout is searched for the pass line
run: compile
	./$(SIM) | tee /dev/stderr | grep -x -F '$(PASS_TEXT)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
